//--- build.f
+incdir+hw
hw/fir_pkg.sv
hw/frame_ctrl_if.sv
hw/tap_mem_if.sv
hw/frame_sequencer.sv
hw/tap_address_unit.sv
hw/tap_ram.sv
hw/mac_unit.sv
hw/fir_top.sv
tests/fir_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the FIR testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module fir_tb -f build.f -o fir_sim

# A crash or assertion stop still shows the log before failing
./obj_dir/fir_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- tests/fir_tb.sv
//****************************************
// Testbench for the FIR filter with clock,
// reset, stimulus, reference and checks
//****************************************
`include "fir_config.svh"

module fir_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fir_pkg::*;

	localparam int n_imp         = `FIR_TAPS; // Impulse and its zero tail
	localparam int n_rand        = 72;        // Wraps the sample ring
	localparam int n_sat         = `FIR_TAPS; // Per saturation run
	localparam int n_total       = n_imp + n_rand + 2 * n_sat;
	localparam int pos_sat_frame = n_imp + n_rand + n_sat - 1;
	localparam int neg_sat_frame = n_total - 1;
	localparam int wait_limit    = `FIR_FRAME_LEN + 40; // Cycles per wait

	logic      alu_clk = 1'b0;
	logic      clk_fast;
	sample_t   din;
	coef_t     cin;
	tap_addr_t caddr;
	logic      cload;
	sample_t   dout;
	logic      valid;
	acc_t      dout_wide;

	coef_t   coef [`FIR_TAPS]; // Written in frame 0 only
	sample_t samples [n_total]; // din per frame, oldest first
	int      errors = 0;
	int      frames_checked = 0;

	fir_top u_dut (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.din       (din),
		.cin       (cin),
		.caddr     (caddr),
		.cload     (cload),
		.dout      (dout),
		.valid     (valid),
		.dout_wide (dout_wide)
	);

	always #10 alu_clk = ~alu_clk; // 20 ns period

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
		end
	endtask

	// Sum of coef[k] * x[n-k], history is zero before frame 0
	function automatic longint ref_acc(input int n);
		longint acc;
		acc = 0;
		for (int k = 0; k < `FIR_TAPS; k++) begin
			if (n - k >= 0)
				acc += longint'(coef[k]) * longint'(samples[n - k]);
		end
		return acc;
	endfunction

	function automatic longint ref_dout(input longint acc);
		longint q;
		q = acc >>> `FIR_COEF_FRAC; // Floor toward minus infinity
		if (q > 32767)
			return 32767;
		if (q < -32768)
			return -32768;
		return q;
	endfunction

	// Polls mid-cycle until valid shows, gives up after wait_limit
	task automatic wait_valid(output bit seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && n < wait_limit) begin
			@(negedge alu_clk);
			seen = valid;
			n++;
		end
		if (!seen) begin
			errors++;
			$display("Timeout while waiting for a valid pulse");
		end
	endtask

	initial begin : stimulus
		bit seen;
		int j;
		int n;
		void'($urandom(32'he22b));
		for (int k = 0; k < `FIR_TAPS; k++)
			coef[k] = coef_t'($urandom); // Full 17-bit range
		for (int f = 0; f < n_total; f++) begin
			j = (f - n_imp - n_rand) % n_sat;
			if (f < n_imp)
				samples[f] = (f == 0) ? sample_t'(1) : sample_t'(0);
			else if (f < n_imp + n_rand)
				samples[f] = sample_t'($urandom);
			else // Full scale, signs lined up with the taps at the last frame of a run
				samples[f] = ((f <= pos_sat_frame) == (coef[n_sat - 1 - j] >= 0)) ?
					sample_t'(32767) : sample_t'(-32768);
		end
		clk_fast = 1'b0;
		din      = samples[0];
		cin      = '0;
		caddr    = '0;
		cload    = 1'b0;
		repeat (16) @(posedge alu_clk);
		clk_fast <= 1'b1;
		for (int k = 0; k < `FIR_TAPS; k++) begin
			cin   <= coef[k]; // One write per cycle
			caddr <= tap_addr_t'(k);
			cload <= 1'b1;
			@(posedge alu_clk);
		end
		cload <= 1'b0;
		for (int f = 1; f < n_total; f++) begin
			wait_valid(seen);
			if (!seen)
				break;
			@(posedge alu_clk);
			din <= samples[f]; // Held through the next latch
			if (f >= n_imp && f < n_imp + n_rand && f % 4 == 0) begin
				@(posedge alu_clk);
				cin   <= coef_t'($urandom); // Late write, must be dropped
				caddr <= tap_addr_t'($urandom);
				cload <= 1'b1;
				@(posedge alu_clk);
				cload <= 1'b0;
			end
		end
		n = 0;
		while (frames_checked < n_total && n < wait_limit) begin
			@(negedge alu_clk);
			n++;
		end
		if (frames_checked < n_total) begin
			errors++;
			$display("Timeout while waiting for the last results");
		end
		$display("Frames checked %0d, errors %0d", frames_checked, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Outputs sampled mid-cycle
	initial begin : compare
		longint acc_exp;
		int     cycle;
		int     last_valid;
		bit     prev_valid;
		cycle      = 0;
		last_valid = 0;
		prev_valid = 1'b0;
		forever begin
			@(negedge alu_clk);
			if (clk_fast)
				cycle++; // Cycles since reset release
			if (valid && frames_checked < n_total) begin
				if (prev_valid) begin
					errors++;
					$display("valid stayed high for more than one cycle at %0t", $time);
				end
				if (frames_checked == 0 && cycle < `FIR_SLEEP_LEN) begin
					errors++;
					$display("First result came before the first sleep phase ended");
				end
				if (frames_checked > 0)
					check_value("valid period", `FIR_FRAME_LEN, cycle - last_valid);
				last_valid = cycle;
				acc_exp = ref_acc(frames_checked);
				check_value("dout_wide", acc_exp, dout_wide);
				check_value("dout", ref_dout(acc_exp), dout);
				if (frames_checked < n_imp)
					check_value("dout_wide impulse tap", coef[frames_checked], dout_wide);
				if (frames_checked == pos_sat_frame)
					check_value("dout positive saturation", 32767, dout);
				if (frames_checked == neg_sat_frame)
					check_value("dout negative saturation", -32768, dout);
				frames_checked++;
			end else if (frames_checked == 0) begin
				check_value("dout", 0, dout); // Nothing before the first result
				check_value("dout_wide", 0, dout_wide);
			end
			prev_valid = valid;
		end
	end

endmodule

//--- hw/fir_top.sv
//****************************************
// FIR filter top, instances only
//****************************************

module fir_top (
	input logic                alu_clk,
	input logic                clk_fast,  // Async reset, active low
	input fir_pkg::sample_t    din,
	input fir_pkg::coef_t      cin,
	input fir_pkg::tap_addr_t  caddr,
	input logic                cload,
	output fir_pkg::sample_t   dout,
	output logic               valid,
	output fir_pkg::acc_t      dout_wide
);
	import fir_pkg::*;

	frame_ctrl_if                  ctrl_if ();  // Phase signals
	tap_mem_if #(.word_t(sample_t)) smem_if (); // Sample ring port
	tap_mem_if #(.word_t(coef_t))   cmem_if (); // Coefficient port

	frame_sequencer u_seq (
		.alu_clk  (alu_clk),
		.clk_fast (clk_fast),
		.ctrl     (ctrl_if)
	);

	tap_address_unit u_addr (
		.alu_clk  (alu_clk),
		.clk_fast (clk_fast),
		.din      (din),
		.cin      (cin),
		.caddr    (caddr),
		.cload    (cload),
		.ctrl     (ctrl_if),
		.smem     (smem_if),
		.cmem     (cmem_if)
	);

	tap_ram #(.word_t(sample_t)) u_smem (
		.alu_clk  (alu_clk),
		.clk_fast (clk_fast),
		.port     (smem_if)
	);

	tap_ram #(.word_t(coef_t)) u_cmem (
		.alu_clk  (alu_clk),
		.clk_fast (clk_fast),
		.port     (cmem_if)
	);

	mac_unit u_mac (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.ctrl      (ctrl_if),
		.smem      (smem_if),
		.cmem      (cmem_if),
		.dout      (dout),
		.dout_wide (dout_wide),
		.valid     (valid)
	);

endmodule

//--- hw/mac_unit.sv
//****************************************
// Multiply-accumulate, rounding with
// saturation, and the result registers
//****************************************
`include "fir_config.svh"

module mac_unit (
	input logic               alu_clk,
	input logic               clk_fast,
	frame_ctrl_if.mac         ctrl,
	tap_mem_if.reader         smem,
	tap_mem_if.reader         cmem,
	output fir_pkg::sample_t  dout,
	output fir_pkg::acc_t     dout_wide,
	output logic              valid
);
	import fir_pkg::*;

	// Signed 16-bit output range
	localparam acc_t sat_max = acc_t'((1 << (`FIR_SAMPLE_W - 1)) - 1);
	localparam acc_t sat_min = -sat_max - acc_t'(1);

	logic                                        mac_dly_r; // mac_active aligned to rdata
	logic signed [`FIR_SAMPLE_W+`FIR_COEF_W-1:0] prod;
	acc_t                                        acc_r;
	acc_t                                        acc_shift;
	sample_t                                     dout_sat;

	assign prod = smem.rdata * cmem.rdata; // Full 33-bit signed product

	// Drop the Q1.15 fraction, floor toward minus infinity
	assign acc_shift = acc_r >>> `FIR_COEF_FRAC;

	always_comb begin
		if (acc_shift > sat_max)
			dout_sat = sat_max[`FIR_SAMPLE_W-1:0];
		else if (acc_shift < sat_min)
			dout_sat = sat_min[`FIR_SAMPLE_W-1:0];
		else
			dout_sat = acc_shift[`FIR_SAMPLE_W-1:0];
	end

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			mac_dly_r <= 1'b0;
			acc_r     <= '0;
			dout      <= '0; // Zero until the first result
			dout_wide <= '0;
			valid     <= 1'b0;
		end else begin
			mac_dly_r <= ctrl.mac_active; // RAM read latency
			if (ctrl.sample_latch)
				acc_r <= '0; // New frame
			else if (mac_dly_r)
				acc_r <= acc_r + acc_t'(prod); // Last tap lands in drain
			if (ctrl.result_strobe) begin
				dout      <= dout_sat;
				dout_wide <= acc_r; // Raw sum, no rounding
			end
			valid <= ctrl.result_strobe;
		end
	end

	// One result per frame, never back to back
	a_valid_pulse: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		valid |=> !valid);

endmodule

//--- hw/tap_ram.sv
//****************************************
// Single-port synchronous RAM, FIR_TAPS
// rows of a typed payload
//****************************************
`include "fir_config.svh"

module tap_ram #(
	parameter type word_t = fir_pkg::sample_t
) (
	input logic    alu_clk,
	input logic    clk_fast,
	tap_mem_if.ram port
);

	word_t mem [`FIR_TAPS]; // One row per tap

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			// Zero history and zero coefficients after reset
			for (int i = 0; i < `FIR_TAPS; i++) begin
				mem[i] <= '0;
			end
			port.rdata <= '0;
		end else begin
			if (port.we)
				mem[port.addr] <= port.wdata;
			port.rdata <= mem[port.addr]; // Old row on a same-address write
		end
	end

endmodule

//--- hw/tap_address_unit.sv
//****************************************
// Circular head pointer, RAM addressing
// and coefficient load routing
//****************************************

module tap_address_unit (
	input logic                alu_clk,
	input logic                clk_fast,
	input fir_pkg::sample_t    din,
	input fir_pkg::coef_t      cin,
	input fir_pkg::tap_addr_t  caddr,
	input logic                cload,
	frame_ctrl_if.addr         ctrl,
	tap_mem_if.ctrl            smem,
	tap_mem_if.ctrl            cmem
);
	import fir_pkg::*;

	tap_addr_t head_r;    // Row of the newest sample
	tap_addr_t head_next;

	assign head_next = head_r + 1'b1; // Wraps at FIR_TAPS

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast)
			head_r <= '0;
		else if (ctrl.sample_latch)
			head_r <= head_next; // One step per frame
	end

	// Sample ring
	always_comb begin
		if (ctrl.sample_latch)
			smem.addr = head_next;            // New sample goes ahead of the old head
		else
			smem.addr = head_r - ctrl.tap_idx; // x[n-k], modulo 64
	end
	assign smem.wdata = din;
	assign smem.we    = ctrl.sample_latch;

	// Coefficients, host port in frame 0 only
	assign cmem.addr  = ctrl.load_window ? caddr : ctrl.tap_idx;
	assign cmem.wdata = cin;
	assign cmem.we    = ctrl.load_window & cload; // Late cload pulses are dropped

	// Window stays shut once closed, so no later coefficient write
	a_coef_wr_window: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		!ctrl.load_window |=> !cmem.we);

endmodule

//--- hw/frame_sequencer.sv
//****************************************
// Frame FSM, shared phase counter and
// the first-frame coefficient window
//****************************************
`include "fir_config.svh"

module frame_sequencer (
	input logic       alu_clk,
	input logic       clk_fast,
	frame_ctrl_if.seq ctrl
);
	import fir_pkg::*;

	// Counter must hold the longest phase
	localparam int cnt_w = $clog2((`FIR_SLEEP_LEN > `FIR_TAPS) ? `FIR_SLEEP_LEN : `FIR_TAPS);

	seq_state_t       state_r;
	logic [cnt_w-1:0] phase_cnt_r;   // Cycles spent in the current phase
	logic             first_frame_r; // Cleared when the first sleep ends

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			state_r       <= st_sleep; // Frame 0 opens in sleep
			phase_cnt_r   <= '0;
			first_frame_r <= 1'b1;
		end else begin
			case (state_r)
			st_sleep: begin
				if (phase_cnt_r == cnt_w'(`FIR_SLEEP_LEN - 1)) begin
					state_r       <= st_latch;
					phase_cnt_r   <= '0;
					first_frame_r <= 1'b0; // Window closes for good
				end else begin
					phase_cnt_r <= phase_cnt_r + 1'b1;
				end
			end
			st_latch: begin
				state_r     <= st_mac;
				phase_cnt_r <= '0; // Tap 0 next
			end
			st_mac: begin
				if (phase_cnt_r == cnt_w'(`FIR_TAPS - 1)) begin
					state_r     <= st_drain;
					phase_cnt_r <= '0;
				end else begin
					phase_cnt_r <= phase_cnt_r + 1'b1;
				end
			end
			st_drain: state_r <= st_done;  // Last product accumulates here
			st_done:  state_r <= st_sleep; // Next frame
			default: begin
				state_r     <= st_sleep;
				phase_cnt_r <= '0;
			end
			endcase
		end
	end

	// Phase decode
	assign ctrl.load_window   = first_frame_r && (state_r == st_sleep);
	assign ctrl.sample_latch  = (state_r == st_latch);
	assign ctrl.mac_active    = (state_r == st_mac);
	assign ctrl.tap_idx       = tap_addr_t'(phase_cnt_r); // Valid only in mac
	assign ctrl.result_strobe = (state_r == st_done);

	// Done never stretches past one cycle
	a_strobe_single: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		ctrl.result_strobe |=> !ctrl.result_strobe);

	// MAC phase ends before the counter passes the last tap
	a_tap_in_range: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		ctrl.mac_active |-> (phase_cnt_r < cnt_w'(`FIR_TAPS)));

endmodule

//--- hw/tap_mem_if.sv
//****************************************
// One RAM port, payload set by type
//****************************************

interface tap_mem_if #(
	parameter type word_t = fir_pkg::sample_t
);
	import fir_pkg::*;

	tap_addr_t addr;  // Row for read and write
	word_t     wdata;
	logic      we;    // Write at the clock edge
	word_t     rdata; // Row contents, one cycle after addr

	// Address generation drives the request
	modport ctrl (output addr, wdata, we);

	modport ram (input addr, wdata, we, output rdata);

	// Read data only
	modport reader (input rdata);

endinterface

//--- hw/frame_ctrl_if.sv
//****************************************
// Frame phase signals from the sequencer
//****************************************

interface frame_ctrl_if;
	import fir_pkg::*;

	logic      load_window;   // First sleep only
	logic      sample_latch;  // Pulse, latch phase
	logic      mac_active;    // Level, 64 cycles
	tap_addr_t tap_idx;       // 0..63 while mac_active
	logic      result_strobe; // Pulse, done phase

	modport seq (
		output load_window, sample_latch, mac_active, tap_idx, result_strobe
	);

	// Address unit side
	modport addr (input load_window, sample_latch, tap_idx);

	// Arithmetic side
	modport mac (input sample_latch, mac_active, result_strobe);

endinterface

//--- hw/fir_pkg.sv
//****************************************
// Data word types and sequencer states
//****************************************
`include "fir_config.svh"

package fir_pkg;

	// Datapath words
	typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`FIR_COEF_W-1:0]   coef_t;
	typedef logic signed [`FIR_ACC_W-1:0]    acc_t;

	// One address covers a tap index and a RAM row
	typedef logic [$clog2(`FIR_TAPS)-1:0] tap_addr_t;

	// Frame phases, in the order they run
	typedef enum logic [2:0] {
		st_sleep, // Idle, coefficient window in frame 0
		st_latch, // din written into the sample ring
		st_mac,   // One tap per cycle
		st_drain, // Last product lands
		st_done   // Result registered
	} seq_state_t;

endpackage

//--- hw/fir_config.svh
//****************************************
// Filter sizes, word widths and the
// frame phase lengths
//****************************************
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

`define FIR_TAPS      64   // Taps, also depth of both RAMs
`define FIR_SLEEP_LEN 106  // Idle cycles at the head of a frame

`define FIR_SAMPLE_W  16   // Signed sample word
`define FIR_COEF_W    17   // Signed Q1.15 coefficient
`define FIR_COEF_FRAC 15   // Fraction bits dropped when rounding
`define FIR_ACC_W     40   // Headroom for 64 full-scale products

// Sleep, then latch, the MAC cycles, drain and done
`define FIR_FRAME_LEN (`FIR_SLEEP_LEN + `FIR_TAPS + 3)

`endif
